//--- verilog.f
verilog/core_ctrl_pkg.sv
verilog/wb_if.sv
verilog/boot_ctrl.sv
verilog/wb_slave_decode.sv
verilog/settings_regs.sv
verilog/readback_mux.sv
verilog/core_ctrl_top.sv
dv/core_ctrl_asserts.sv
dv/core_ctrl_tb.sv

//--- Makefile
# Verilator build and run of the control core testbench

VERILATOR ?= verilator
TOP       ?= core_ctrl_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: run build lint clean

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/core_ctrl_tb.sv
// Directed testbench for the control core bus, setting registers, readback and boot FSM
`timescale 1ns/1ps

module core_ctrl_tb;

   // Directed tests take about 110 cycles
   localparam int MAX_CYCLES = 2000;
   localparam int ACK_LIMIT  = 8;

   logic                     wb_clk;
   logic                     por_rst;
   core_ctrl_pkg::adr_t      wb_adr;
   core_ctrl_pkg::dat_t      wb_dat_w;
   logic                     wb_we;
   logic                     wb_stb;
   logic                     wb_cyc;
   core_ctrl_pkg::dat_t      wb_dat_r;
   logic                     wb_ack;
   logic [3:0]               run_flags;
   logic                     aux_ld1;
   logic                     aux_ld2;
   logic                     button;
   core_ctrl_pkg::adr_t      bus_adr;
   logic                     soft_rst;
   core_ctrl_pkg::lms_res_t  lms_res;
   logic                     phy_resetn;
   logic                     div_sw1;
   logic                     div_sw2;
   core_ctrl_pkg::led_t      leds;

   logic [31:0] lfsr_state = 32'h2a35_e4c8;
   int          cycles = 0;
   int          tests = 0;
   int          checks = 0;
   int          errors = 0;

   core_ctrl_top i_core_ctrl_top (
      .wb_clk       (wb_clk),
      .por_rst      (por_rst),
      .wb_adr_i     (wb_adr),
      .wb_dat_i     (wb_dat_w),
      .wb_we_i      (wb_we),
      .wb_stb_i     (wb_stb),
      .wb_cyc_i     (wb_cyc),
      .wb_dat_o     (wb_dat_r),
      .wb_ack_o     (wb_ack),
      .run_flags_i  (run_flags),
      .aux_ld1_i    (aux_ld1),
      .aux_ld2_i    (aux_ld2),
      .button_i     (button),
      .bus_adr_o    (bus_adr),
      .soft_rst_o   (soft_rst),
      .lms_res_o    (lms_res),
      .phy_resetn_o (phy_resetn),
      .div_sw1_o    (div_sw1),
      .div_sw2_o    (div_sw2),
      .leds_o       (leds)
   );

   always #10 wb_clk = ~wb_clk;

   always @(posedge wb_clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, the tests did not finish", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random bits and expected values

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic core_ctrl_pkg::dat_t rand_bits(input int n);
      core_ctrl_pkg::dat_t v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   function automatic core_ctrl_pkg::adr_t set_adr(input core_ctrl_pkg::set_addr_t sa);
      return 16'h7000 | {6'b000000, sa, 2'b00};
   endfunction

   function automatic core_ctrl_pkg::adr_t rb_adr(input core_ctrl_pkg::rb_idx_t idx);
      return 16'h5C00 | {10'h000, idx, 2'b00};
   endfunction

   // Run flag n lands on LED n+1
   // Source bit 1 selects hardware
   function automatic core_ctrl_pkg::led_t expected_leds(input core_ctrl_pkg::led_t src,
                                                         input core_ctrl_pkg::led_t sw,
                                                         input logic [3:0] flags);
      core_ctrl_pkg::led_t hw;
      core_ctrl_pkg::led_t res;
      hw = '0;
      for (int i = 0; i < 4; i++) begin
         hw[i+1] = flags[i];
      end
      for (int i = 0; i < 8; i++) begin
         res[i] = src[i] ? hw[i] : sw[i];
      end
      return res;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Compare tasks

   task automatic note_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
   endtask

   task automatic check_dat(input string name, input core_ctrl_pkg::dat_t got,
                            input core_ctrl_pkg::dat_t exp);
      checks++;
      if (got !== exp) begin
         note_error(name, got, exp);
      end
   endtask

   task automatic check_adr(input string name, input core_ctrl_pkg::adr_t got,
                            input core_ctrl_pkg::adr_t exp);
      checks++;
      if (got !== exp) begin
         note_error(name, 32'(got), 32'(exp));
      end
   endtask

   task automatic check_led(input string name, input core_ctrl_pkg::led_t got,
                            input core_ctrl_pkg::led_t exp);
      checks++;
      if (got !== exp) begin
         note_error(name, 32'(got), 32'(exp));
      end
   endtask

   task automatic check_lms(input string name, input core_ctrl_pkg::lms_res_t got,
                            input core_ctrl_pkg::lms_res_t exp);
      checks++;
      if (got !== exp) begin
         note_error(name, 32'(got), 32'(exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         note_error(name, 32'(got), 32'(exp));
      end
   endtask

   task automatic report_test(input string name, input int start);
      tests++;
      $display("%-16s %s", name, (errors == start) ? "ok" : "failed");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Bus access with stb held until ack

   task automatic run_access(input core_ctrl_pkg::adr_t adr, input logic we,
                             input core_ctrl_pkg::dat_t wdat,
                             output core_ctrl_pkg::dat_t rdat);
      int waited;
      waited = 0;
      @(posedge wb_clk);
      #1;
      wb_adr   = adr;
      wb_dat_w = wdat;
      wb_we    = we;
      wb_stb   = 1'b1;
      wb_cyc   = 1'b1;
      do begin
         @(posedge wb_clk);
         #1;
         waited++;
      end while (!wb_ack && waited < ACK_LIMIT);
      if (!wb_ack) begin
         errors++;
         $display("No ack within %0d cycles for the access at %h", ACK_LIMIT, adr);
      end else if (waited != 1) begin
         errors++;
         $display("Ack for the access at %h came after %0d cycles instead of one",
                  adr, waited);
      end
      rdat   = wb_dat_r;
      wb_stb = 1'b0;
      wb_cyc = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input core_ctrl_pkg::adr_t adr, input core_ctrl_pkg::dat_t dat);
      core_ctrl_pkg::dat_t unused;
      run_access(adr, 1'b1, dat, unused);
   endtask

   task automatic bus_read(input core_ctrl_pkg::adr_t adr, output core_ctrl_pkg::dat_t dat);
      run_access(adr, 1'b0, '0, dat);
   endtask

   task automatic check_map(input core_ctrl_pkg::adr_t raw, input core_ctrl_pkg::adr_t exp);
      @(posedge wb_clk);
      #1;
      wb_adr = raw;
      @(posedge wb_clk);
      #1;
      check_adr("bus_adr_o", bus_adr, exp);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Directed tests

   task automatic test_reset_values();
      int start;
      start = errors;
      run_flags = 4'(rand_bits(4));
      @(posedge wb_clk);
      #1;
      check_lms("lms_res_o", lms_res, 2'b00);
      check_bit("phy_resetn_o", phy_resetn, 1'b1);
      check_bit("div_sw1_o", div_sw1, 1'b1);
      check_bit("div_sw2_o", div_sw2, 1'b1);
      check_led("leds_o", leds, expected_leds(8'hFF, 8'h00, run_flags));
      report_test("reset_values", start);
   endtask

   task automatic test_settings();
      int                  start;
      core_ctrl_pkg::dat_t d;
      core_ctrl_pkg::led_t sw;
      core_ctrl_pkg::led_t src;
      start = errors;
      for (int n = 0; n < 4; n++) begin
         d = rand_bits(32);
         bus_write(set_adr(core_ctrl_pkg::SR_LMS_RES), d);
         check_lms("lms_res_o", lms_res, d[1:0]);
         d = rand_bits(32);
         bus_write(set_adr(core_ctrl_pkg::SR_PHY_RST), d);
         check_bit("phy_resetn_o", phy_resetn, ~d[0]);
         d = rand_bits(32);
         bus_write(set_adr(core_ctrl_pkg::SR_DIVSW1), d);
         check_bit("div_sw1_o", div_sw1, d[0]);
         d = rand_bits(32);
         bus_write(set_adr(core_ctrl_pkg::SR_DIVSW2), d);
         check_bit("div_sw2_o", div_sw2, d[0]);
         run_flags = 4'(rand_bits(4));
         sw  = 8'(rand_bits(8));
         src = 8'(rand_bits(8));
         bus_write(set_adr(core_ctrl_pkg::SR_LED_SW), {24'h000000, sw});
         bus_write(set_adr(core_ctrl_pkg::SR_LED_SRC), {24'h000000, src});
         check_led("leds_o", leds, expected_leds(src, sw, run_flags));
      end
      report_test("settings", start);
   endtask

   task automatic test_readback();
      int                  start;
      core_ctrl_pkg::dat_t rd;
      core_ctrl_pkg::dat_t exp;
      start = errors;
      bus_read(rb_adr(core_ctrl_pkg::RB_COMPAT), rd);
      check_dat("compat word", rd, 32'h0009_0000);
      for (int k = 0; k < 8; k++) begin
         button  = k[0];
         aux_ld1 = k[1];
         aux_ld2 = k[2];
         bus_read(rb_adr(core_ctrl_pkg::RB_AUX), rd);
         exp = '0;
         exp[13] = k[0];
         exp[14] = k[1];
         exp[15] = k[2];
         check_dat("aux word", rd, exp);
      end
      bus_read(rb_adr(4'd0), rd);
      check_dat("slot 0", rd, '0);
      bus_read(rb_adr(4'd10), rd);
      check_dat("slot 10", rd, '0);
      report_test("readback", start);
   endtask

   task automatic test_boot();
      int start;
      int waited;
      start  = errors;
      waited = 0;
      check_map(16'h0000, 16'hC000);
      check_map(16'hF000, 16'h3000);
      check_map(16'h5C00, 16'h5C00);
      // Move settings away from reset so the soft reset shows
      bus_write(set_adr(core_ctrl_pkg::SR_LMS_RES), 32'h3);
      bus_write(set_adr(core_ctrl_pkg::SR_PHY_RST), 32'h1);
      bus_write(set_adr(core_ctrl_pkg::SR_DIVSW1), 32'h0);
      bus_write(set_adr(core_ctrl_pkg::SR_DIVSW2), 32'h0);
      bus_write(set_adr(core_ctrl_pkg::SR_LED_SRC), 32'h0);
      bus_write(set_adr(core_ctrl_pkg::SR_BLDR_DONE), 32'h1);
      while (!soft_rst && waited < ACK_LIMIT) begin
         @(posedge wb_clk);
         #1;
         waited++;
      end
      checks++;
      if (!soft_rst) begin
         errors++;
         $display("soft_rst_o never went high after the bootloader done write");
      end
      repeat (6) begin
         @(posedge wb_clk);
         #1;
         check_bit("soft_rst_o", soft_rst, 1'b0);
      end
      check_lms("lms_res_o", lms_res, 2'b00);
      check_bit("phy_resetn_o", phy_resetn, 1'b1);
      check_bit("div_sw1_o", div_sw1, 1'b1);
      check_bit("div_sw2_o", div_sw2, 1'b1);
      check_led("leds_o", leds, expected_leds(core_ctrl_pkg::LED_SRC_RESET, '0, run_flags));
      check_map(16'h0000, 16'h0000);
      check_map(16'hF000, 16'hF000);
      check_map(16'h5C00, 16'h5C00);
      report_test("boot", start);
   endtask

   task automatic test_unmapped();
      int                  start;
      core_ctrl_pkg::dat_t rd;
      start = errors;
      bus_read(16'h9000, rd);
      check_dat("unmapped read", rd, '0);
      report_test("unmapped", start);
   endtask

   initial begin
      wb_clk    = 1'b0;
      por_rst   = 1'b1;
      wb_adr    = '0;
      wb_dat_w  = '0;
      wb_we     = 1'b0;
      wb_stb    = 1'b0;
      wb_cyc    = 1'b0;
      run_flags = '0;
      aux_ld1   = 1'b0;
      aux_ld2   = 1'b0;
      button    = 1'b0;
      repeat (3) @(posedge wb_clk);
      #1;
      por_rst = 1'b0;
      test_reset_values();
      test_settings();
      test_readback();
      test_boot();
      test_unmapped();
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- dv/core_ctrl_asserts.sv
// Bus handshake and soft reset assertions bound to the address decoder
`timescale 1ns/1ps

module core_ctrl_asserts (
   input logic wb_clk,
   input logic rst_i,
   input logic stb_i,
   input logic cyc_i,
   input logic ack_i
);

   // Set once power-on reset has ended
   logic rst_seen_low = 1'b0;

   always @(posedge wb_clk) begin
      if (!rst_i) begin
         rst_seen_low <= 1'b1;
      end
   end

   ack_one_cycle: assert property (@(posedge wb_clk) disable iff (rst_i)
      ack_i |=> !ack_i)
      else $error("ack stayed high for more than one cycle");

   // Master drops stb in the ack cycle, so look one cycle back
   ack_after_stb: assert property (@(posedge wb_clk) disable iff (rst_i)
      ack_i |-> $past(stb_i && cyc_i))
      else $error("ack without a preceding stb and cyc");

   soft_rst_pulse: assert property (@(posedge wb_clk)
      (rst_seen_low && rst_i) |=> !rst_i)
      else $error("soft reset lasted more than one cycle");

endmodule

bind wb_slave_decode core_ctrl_asserts i_core_ctrl_asserts (
   .wb_clk (wb_clk),
   .rst_i  (rst_i),
   .stb_i  (stb_i),
   .cyc_i  (cyc_i),
   .ack_i  (ack_o)
);

//--- verilog/core_ctrl_top.sv
// Control core top level with boot control, decoder, settings and readback
`timescale 1ns/1ps

module core_ctrl_top #(
   parameter core_ctrl_pkg::dat_t COMPAT_NUM = core_ctrl_pkg::COMPAT_DEFAULT
) (
   input  logic                      wb_clk,
   input  logic                      por_rst,
   // Bus master port
   input  core_ctrl_pkg::adr_t       wb_adr_i,
   input  core_ctrl_pkg::dat_t       wb_dat_i,
   input  logic                      wb_we_i,
   input  logic                      wb_stb_i,
   input  logic                      wb_cyc_i,
   output core_ctrl_pkg::dat_t       wb_dat_o,
   output logic                      wb_ack_o,
   // Status inputs
   input  logic [3:0]                run_flags_i,
   input  logic                      aux_ld1_i,
   input  logic                      aux_ld2_i,
   input  logic                      button_i,
   // Control outputs
   output core_ctrl_pkg::adr_t       bus_adr_o,
   output logic                      soft_rst_o,
   output core_ctrl_pkg::lms_res_t   lms_res_o,
   output logic                      phy_resetn_o,
   output logic                      div_sw1_o,
   output logic                      div_sw2_o,
   output core_ctrl_pkg::led_t       leds_o
);

   logic bldr_done;
   wire  ctrl_rst = por_rst | soft_rst_o;

   wb_if #(.AW(core_ctrl_pkg::ADR_W), .DW(core_ctrl_pkg::DAT_W)) set_bus ();
   wb_if #(.AW(core_ctrl_pkg::ADR_W), .DW(core_ctrl_pkg::DAT_W)) rb_bus ();

   boot_ctrl i_boot_ctrl (
      .wb_clk      (wb_clk),
      .por_rst     (por_rst),
      .cpu_adr_i   (wb_adr_i),
      .bldr_done_i (bldr_done),
      .bus_adr_o   (bus_adr_o),
      .soft_rst_o  (soft_rst_o)
   );

   wb_slave_decode i_wb_slave_decode (
      .wb_clk  (wb_clk),
      .rst_i   (ctrl_rst),
      .adr_i   (bus_adr_o),
      .dat_i   (wb_dat_i),
      .we_i    (wb_we_i),
      .stb_i   (wb_stb_i),
      .cyc_i   (wb_cyc_i),
      .dat_o   (wb_dat_o),
      .ack_o   (wb_ack_o),
      .set_bus (set_bus.master),
      .rb_bus  (rb_bus.master)
   );

   settings_regs i_settings_regs (
      .bus          (set_bus.slave),
      .wb_clk       (wb_clk),
      .rst_i        (ctrl_rst),
      .run_flags_i  (run_flags_i),
      .lms_res_o    (lms_res_o),
      .phy_resetn_o (phy_resetn_o),
      .bldr_done_o  (bldr_done),
      .div_sw1_o    (div_sw1_o),
      .div_sw2_o    (div_sw2_o),
      .leds_o       (leds_o)
   );

   readback_mux #(.COMPAT_NUM(COMPAT_NUM)) i_readback_mux (
      .bus       (rb_bus.slave),
      .wb_clk    (wb_clk),
      .rst_i     (ctrl_rst),
      .aux_ld1_i (aux_ld1_i),
      .aux_ld2_i (aux_ld2_i),
      .button_i  (button_i)
   );

endmodule

//--- verilog/readback_mux.sv
// Readback slave returning one of sixteen status words
`timescale 1ns/1ps

module readback_mux #(
   parameter core_ctrl_pkg::dat_t COMPAT_NUM = core_ctrl_pkg::COMPAT_DEFAULT
) (
   wb_if.slave   bus,
   input  logic  wb_clk,
   input  logic  rst_i,
   input  logic  aux_ld1_i,
   input  logic  aux_ld2_i,
   input  logic  button_i
);

   core_ctrl_pkg::rb_idx_t idx;
   core_ctrl_pkg::dat_t    word;
   core_ctrl_pkg::dat_t    dat_q;
   logic                   ack_q;

   assign idx = bus.adr[5:2];

   // Slots of dropped blocks read as zero
   always_comb begin
      case (idx)
         core_ctrl_pkg::RB_COMPAT: word = COMPAT_NUM;
         core_ctrl_pkg::RB_AUX:    word = {16'h0000, aux_ld2_i, aux_ld1_i, button_i, 13'h0000};
         default:                  word = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus.stb & ~ack_q;
      end
   end

   // Word captured with the ack
   always_ff @(posedge wb_clk) begin
      if (bus.stb & ~ack_q) begin
         dat_q <= word;
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;

endmodule

//--- verilog/settings_regs.sv
// Settings bus write port with setting registers and the LED source mux
`timescale 1ns/1ps

module settings_regs (
   wb_if.slave                       bus,
   input  logic                      wb_clk,
   input  logic                      rst_i,
   input  logic [3:0]                run_flags_i,
   output core_ctrl_pkg::lms_res_t   lms_res_o,
   output logic                      phy_resetn_o,
   output logic                      bldr_done_o,
   output logic                      div_sw1_o,
   output logic                      div_sw2_o,
   output core_ctrl_pkg::led_t       leds_o
);

   logic                      ack_q;
   logic                      set_stb;
   core_ctrl_pkg::set_addr_t  set_addr;
   core_ctrl_pkg::dat_t       set_data;
   logic                      phy_rst;
   core_ctrl_pkg::led_t       led_sw;
   core_ctrl_pkg::led_t       led_src;
   core_ctrl_pkg::led_t       led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Bus to settings strobe

   // One strobe per write, on the edge that raises ack
   assign set_stb  = bus.stb & bus.we & ~ack_q;
   assign set_addr = bus.adr[9:2];
   assign set_data = bus.dat_w;

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= bus.stb & ~ack_q;
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = '0;   // write only

   ////////////////////////////////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         lms_res_o   <= '0;
         phy_rst     <= 1'b0;
         bldr_done_o <= 1'b0;
         led_sw      <= '0;
         led_src     <= core_ctrl_pkg::LED_SRC_RESET;
         div_sw1_o   <= core_ctrl_pkg::DIVSW_RESET;
         div_sw2_o   <= core_ctrl_pkg::DIVSW_RESET;
      end else if (set_stb) begin
         case (set_addr)
            core_ctrl_pkg::SR_LMS_RES:   lms_res_o   <= set_data[1:0];
            core_ctrl_pkg::SR_LED_SW:    led_sw      <= set_data[7:0];
            core_ctrl_pkg::SR_PHY_RST:   phy_rst     <= set_data[0];
            core_ctrl_pkg::SR_BLDR_DONE: bldr_done_o <= set_data[0];
            core_ctrl_pkg::SR_LED_SRC:   led_src     <= set_data[7:0];
            core_ctrl_pkg::SR_DIVSW1:    div_sw1_o   <= set_data[0];
            core_ctrl_pkg::SR_DIVSW2:    div_sw2_o   <= set_data[0];
            default: begin
               // Other addresses belong to dropped blocks
            end
         endcase
      end
   end

   assign phy_resetn_o = ~phy_rst;

   ////////////////////////////////////////////////////////////////////////////
   // LED mux

   // Run flags tx0, rx0, tx1, rx1 on LEDs 4 to 1
   assign led_hw = {3'b000, run_flags_i, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

//--- verilog/wb_slave_decode.sv
// Address decoder from the master port to the settings and readback slaves
`timescale 1ns/1ps

module wb_slave_decode (
   input  logic                 wb_clk,
   input  logic                 rst_i,
   input  core_ctrl_pkg::adr_t  adr_i,
   input  core_ctrl_pkg::dat_t  dat_i,
   input  logic                 we_i,
   input  logic                 stb_i,
   input  logic                 cyc_i,
   output core_ctrl_pkg::dat_t  dat_o,
   output logic                 ack_o,
   wb_if.master                 set_bus,
   wb_if.master                 rb_bus
);

   logic [7:0] page;
   logic       req;
   logic       set_hit;
   logic       rb_hit;
   logic       none_ack;

   assign page = adr_i[15:8];
   assign req  = stb_i & cyc_i;

   assign set_hit = (page & core_ctrl_pkg::SETTINGS_MASK) == core_ctrl_pkg::SETTINGS_BASE;
   assign rb_hit  = (page & core_ctrl_pkg::READBACK_MASK) == core_ctrl_pkg::READBACK_BASE;

   ////////////////////////////////////////////////////////////////////////////
   // Slave request paths

   assign set_bus.adr   = adr_i;
   assign set_bus.dat_w = dat_i;
   assign set_bus.we    = we_i;
   assign set_bus.stb   = req & set_hit;

   assign rb_bus.adr    = adr_i;
   assign rb_bus.dat_w  = dat_i;
   assign rb_bus.we     = we_i;
   assign rb_bus.stb    = req & rb_hit;

   ////////////////////////////////////////////////////////////////////////////
   // Unmapped windows

   // Acknowledge with zero data so the master never hangs
   always_ff @(posedge wb_clk) begin
      if (rst_i) begin
         none_ack <= 1'b0;
      end else begin
         none_ack <= req & ~set_hit & ~rb_hit & ~none_ack;
      end
   end

   // Return path
   always_comb begin
      if (set_hit) begin
         dat_o = set_bus.dat_r;
      end else if (rb_hit) begin
         dat_o = rb_bus.dat_r;
      end else begin
         dat_o = '0;
      end
   end

   assign ack_o = set_bus.ack | rb_bus.ack | none_ack;

endmodule

//--- verilog/boot_ctrl.sv
// Boot control FSM with boot RAM address swap and soft reset pulse
`timescale 1ns/1ps

module boot_ctrl (
   input  logic                 wb_clk,
   input  logic                 por_rst,
   input  core_ctrl_pkg::adr_t  cpu_adr_i,
   input  logic                 bldr_done_i,
   output core_ctrl_pkg::adr_t  bus_adr_o,
   output logic                 soft_rst_o
);

   core_ctrl_pkg::boot_state_t state;
   logic                       swap;

   ////////////////////////////////////////////////////////////////////////////
   // Boot FSM, only power-on reset brings it back to BOOT_WAIT

   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state      <= core_ctrl_pkg::BOOT_WAIT;
         soft_rst_o <= 1'b1;
      end else begin
         case (state)
            core_ctrl_pkg::BOOT_WAIT: begin
               // Bootloader hands over, pulse reset to the rest
               soft_rst_o <= bldr_done_i;
               if (bldr_done_i) begin
                  state <= core_ctrl_pkg::BOOT_DONE;
               end
            end
            core_ctrl_pkg::BOOT_DONE: begin
               soft_rst_o <= 1'b0;
            end
            default: begin
               state      <= core_ctrl_pkg::BOOT_WAIT;
               soft_rst_o <= 1'b0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Address swap

   // Lowest and highest 16K windows trade places while booting
   assign swap = (state == core_ctrl_pkg::BOOT_WAIT) &&
                 (cpu_adr_i[15] == cpu_adr_i[14]);

   assign bus_adr_o = swap ? (cpu_adr_i ^ core_ctrl_pkg::BOOT_SWAP) : cpu_adr_i;

endmodule

//--- verilog/wb_if.sv
// Single-slave bus between the address decoder and one slave
`timescale 1ns/1ps

interface wb_if #(
   parameter int AW = 16,
   parameter int DW = 32
) ();

   logic [AW-1:0] adr;
   logic [DW-1:0] dat_w;
   logic [DW-1:0] dat_r;
   logic          we;
   logic          stb;
   logic          ack;

   // Decoder side
   modport master (
      output adr, dat_w, we, stb,
      input  dat_r, ack
   );

   // Slave side, ack one cycle after stb
   modport slave (
      input  adr, dat_w, we, stb,
      output dat_r, ack
   );

endinterface

//--- verilog/core_ctrl_pkg.sv
// Control core package with bus widths, address map, setting addresses and types
package core_ctrl_pkg;

   // Bus widths, byte addressed
   localparam int ADR_W = 16;
   localparam int DAT_W = 32;

   typedef logic [ADR_W-1:0] adr_t;
   typedef logic [DAT_W-1:0] dat_t;
   typedef logic [7:0]       set_addr_t;   // Bus address bits 9 to 2
   typedef logic [7:0]       led_t;
   typedef logic [1:0]       lms_res_t;
   typedef logic [3:0]       rb_idx_t;     // Bus address bits 5 to 2

   typedef enum logic {
      BOOT_WAIT,
      BOOT_DONE
   } boot_state_t;

   // Slave windows, matched on address bits 15 to 8
   localparam logic [7:0] SETTINGS_BASE = 8'h70;
   localparam logic [7:0] SETTINGS_MASK = 8'hF0;
   localparam logic [7:0] READBACK_BASE = 8'h5C;
   localparam logic [7:0] READBACK_MASK = 8'hFC;

   // Boot RAM and main RAM trade places until the bootloader is done
   localparam adr_t BOOT_SWAP = 16'hC000;

   // Setting addresses
   localparam set_addr_t SR_MISC      = 8'd0;
   localparam set_addr_t SR_LMS_RES   = SR_MISC + 8'd0;
   localparam set_addr_t SR_LED_SW    = SR_MISC + 8'd3;
   localparam set_addr_t SR_PHY_RST   = SR_MISC + 8'd4;
   localparam set_addr_t SR_BLDR_DONE = SR_MISC + 8'd5;
   localparam set_addr_t SR_LED_SRC   = SR_MISC + 8'd6;
   localparam set_addr_t SR_DIVSW     = 8'd180;
   localparam set_addr_t SR_DIVSW1    = SR_DIVSW + 8'd0;
   localparam set_addr_t SR_DIVSW2    = SR_DIVSW + 8'd1;

   // Reset values, LEDs 4 to 1 on hardware flags
   localparam led_t LED_SRC_RESET = 8'h1E;
   localparam logic DIVSW_RESET   = 1'b1;

   // Readback slots
   localparam rb_idx_t RB_COMPAT = 4'd12;
   localparam rb_idx_t RB_AUX    = 4'd13;

   // Major in the upper half, minor in the lower half
   localparam dat_t COMPAT_DEFAULT = {16'd9, 16'd0};

endpackage
